// ==== dp_num_pkg.sv ====
package dp_num_pkg;

  // signed Q8.8 activations
  // the result beat uses the same format
  localparam int act_width = 16;
  localparam int act_frac  = 8;

  // signed Q2.6 weights
  localparam int wgt_width = 8;
  localparam int wgt_frac  = 6;

  // full precision product
  // fraction bits add up to act_frac + wgt_frac
  localparam int prod_width = act_width + wgt_width;

  // one vector element of each kind
  typedef logic signed [act_width-1:0] act_t;

  typedef logic signed [wgt_width-1:0] wgt_t;

  typedef logic signed [prod_width-1:0] prod_t;

  // vectors are packed arrays of these, sized by IN_SIZE
  // at the module that owns them

  // sum width grows with IN_SIZE, so it is not fixed here
  // each user computes prod_width + $clog2(IN_SIZE)

endpackage

// ==== dp_stream_pkg.sv ====
package dp_stream_pkg;

  // result beat on the output stream
  //   value  rounded and clamped Q8.8 result
  //   sat    set when value was clamped to a rail
  typedef struct packed {
    dp_num_pkg::act_t value;
    logic             sat;
  } out_beat_t;

  // 17 bits in total
  localparam int out_beat_width = $bits(out_beat_t);

  // the input and internal streams carry packed arrays of
  // dp_num_pkg element types plus a valid and a ready, so they
  // need no struct of their own

  // a beat moves on a rising clk edge with valid and ready high
  // valid and payload hold until that edge

  // only one output lane exists, so no lane index travels
  // with the beat

endpackage

// ==== fixed_adder_tree.sv ====
`timescale 1ns/1ps

module fixed_adder_tree #(
  parameter  int IN_SIZE = 4,
  localparam int SUM_W   = dp_num_pkg::prod_width + $clog2(IN_SIZE)
) (
  input  logic                             clk,
  input  logic                             rst_n,

  // product vector from the multiplier
  input  dp_num_pkg::prod_t [IN_SIZE-1:0]  prod,
  input  logic                             prod_valid,
  output logic                             prod_ready,

  // exact sum of all products
  output logic signed [SUM_W-1:0]          sum,
  output logic                             sum_valid,
  input  logic                             sum_ready
);

  localparam int LEVELS = $clog2(IN_SIZE);
  localparam int PW     = dp_num_pkg::prod_width;

  if (IN_SIZE < 2 || (IN_SIZE & (IN_SIZE - 1)) != 0) begin : g_size_check
    $error("fixed_adder_tree: IN_SIZE %0d must be a power of two >= 2", IN_SIZE);
  end

  // one register level per tree level
  // level l halves the node count and grows by one bit
  for (genvar l = 0; l < LEVELS; l++) begin : lvl
    localparam int N = IN_SIZE >> (l + 1);
    localparam int W = PW + l + 1;

    logic signed [W-2:0] a    [2*N];
    logic signed [W-1:0] node [N];
    logic                in_valid;
    logic                out_ready;
    logic                load;
    logic                v;

    // operands come from the ports or from the level before
    if (l == 0) begin : g_src
      for (genvar i = 0; i < 2 * N; i++) begin : g_in
        assign a[i] = prod[i];
      end
      assign in_valid = prod_valid;
    end else begin : g_src
      assign a        = lvl[l-1].node;
      assign in_valid = lvl[l-1].v;
    end

    // last level drains into the sum port
    if (l == LEVELS - 1) begin : g_dst
      assign out_ready = sum_ready;
    end else begin : g_dst
      assign out_ready = lvl[l+1].load;
    end

    // stage rule, empty or being taken
    assign load = !v || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        v <= 1'b0;
      end else if (load) begin
        v <= in_valid;
      end
    end

    // neighbouring pairs, sign extended by the add
    always_ff @(posedge clk) begin
      if (load && in_valid) begin
        for (int i = 0; i < N; i++) begin
          node[i] <= a[2*i] + a[2*i+1];
        end
      end
    end
  end

  assign prod_ready = lvl[0].load;

  // a single node is left at the root
  assign sum       = lvl[LEVELS-1].node[0];
  assign sum_valid = lvl[LEVELS-1].v;

  // an X on sum_valid would poison every stage above it
  property p_sum_valid_known;
    @(posedge clk) disable iff (!rst_n)
      !$isunknown(sum_valid);
  endproperty

  a_sum_valid_known: assert property (p_sum_valid_known)
    else $error("fixed_adder_tree: sum_valid is unknown");

endmodule

// ==== fixed_dot_product.sv ====
`timescale 1ns/1ps

module fixed_dot_product #(
  parameter  int IN_SIZE = 4,
  localparam int SUM_W   = dp_num_pkg::prod_width + $clog2(IN_SIZE)
) (
  input  logic                             clk,
  input  logic                             rst_n,

  // activation stream
  input  dp_num_pkg::act_t [IN_SIZE-1:0]   act,
  input  logic                             act_valid,
  output logic                             act_ready,

  // weight stream
  input  dp_num_pkg::wgt_t [IN_SIZE-1:0]   wgt,
  input  logic                             wgt_valid,
  output logic                             wgt_ready,

  // summed products
  output logic signed [SUM_W-1:0]          sum,
  output logic                             sum_valid,
  input  logic                             sum_ready
);

  dp_num_pkg::prod_t [IN_SIZE-1:0] pv;
  logic                            pv_valid;
  logic                            pv_ready;

  // join the two streams and multiply
  fixed_vector_mult #(
    .IN_SIZE(IN_SIZE)
  ) fixed_vector_mult_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .act       (act),
    .act_valid (act_valid),
    .act_ready (act_ready),
    .wgt       (wgt),
    .wgt_valid (wgt_valid),
    .wgt_ready (wgt_ready),
    .prod      (pv),
    .prod_valid(pv_valid),
    .prod_ready(pv_ready)
  );

  // sum = sum(pv)
  fixed_adder_tree #(
    .IN_SIZE(IN_SIZE)
  ) fixed_adder_tree_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .prod      (pv),
    .prod_valid(pv_valid),
    .prod_ready(pv_ready),
    .sum       (sum),
    .sum_valid (sum_valid),
    .sum_ready (sum_ready)
  );

endmodule

// ==== fixed_linear_unit.sv ====
`timescale 1ns/1ps

module fixed_linear_unit #(
  parameter int IN_SIZE = 4
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  dp_num_pkg::act_t [IN_SIZE-1:0]  act,
  input  logic                            act_valid,
  output logic                            act_ready,
  input  dp_num_pkg::wgt_t [IN_SIZE-1:0]  wgt,
  input  logic                            wgt_valid,
  output logic                            wgt_ready,
  output dp_stream_pkg::out_beat_t        res,
  output logic                            res_valid,
  input  logic                            res_ready
);

  localparam int SUM_W = dp_num_pkg::prod_width + $clog2(IN_SIZE);

  logic signed [SUM_W-1:0] sum;
  logic                    sum_valid;
  logic                    sum_ready;

  // 1 + log2(IN_SIZE) cycles to the full-precision sum
  fixed_dot_product #(
    .IN_SIZE(IN_SIZE)
  ) fixed_dot_product_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .act      (act),
    .act_valid(act_valid),
    .act_ready(act_ready),
    .wgt      (wgt),
    .wgt_valid(wgt_valid),
    .wgt_ready(wgt_ready),
    .sum      (sum),
    .sum_valid(sum_valid),
    .sum_ready(sum_ready)
  );

  // back to Q8.8, one more cycle
  fixed_round_sat #(
    .IN_SIZE(IN_SIZE)
  ) fixed_round_sat_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .sum      (sum),
    .sum_valid(sum_valid),
    .sum_ready(sum_ready),
    .res      (res),
    .res_valid(res_valid),
    .res_ready(res_ready)
  );

endmodule

// ==== fixed_round_sat.sv ====
`timescale 1ns/1ps

module fixed_round_sat #(
  parameter  int IN_SIZE = 4,
  localparam int SUM_W   = dp_num_pkg::prod_width + $clog2(IN_SIZE)
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic signed [SUM_W-1:0]  sum,
  input  logic                     sum_valid,
  output logic                     sum_ready,
  output dp_stream_pkg::out_beat_t res,
  output logic                     res_valid,
  input  logic                     res_ready
);

  // sum carries act_frac + wgt_frac fraction bits
  localparam int PROD_FRAC = dp_num_pkg::act_frac + dp_num_pkg::wgt_frac;
  localparam int SHIFT     = PROD_FRAC - dp_num_pkg::act_frac;
  localparam int AW        = dp_num_pkg::act_width;
  localparam int SHW       = SUM_W + 1 - SHIFT;

  // half an output lsb, for round-half-up
  localparam logic signed [SUM_W:0] RND = 1 << (SHIFT - 1);

  localparam logic signed [AW-1:0]  ACT_MAX = (1 << (AW - 1)) - 1;
  localparam logic signed [AW-1:0]  ACT_MIN = -(1 << (AW - 1));
  localparam logic signed [SHW-1:0] MAX_V   = ACT_MAX;
  localparam logic signed [SHW-1:0] MIN_V   = ACT_MIN;

  logic signed [SUM_W:0]    rnd;
  logic signed [SHW-1:0]    shf;
  dp_stream_pkg::out_beat_t beat_d;
  logic                     load;

  // one extra bit so the rounding add cannot wrap
  assign rnd = sum + RND;
  // arithmetic shift right by SHIFT
  assign shf = rnd[SUM_W:SHIFT];

  always_comb begin
    beat_d.sat   = 1'b1;
    beat_d.value = shf[AW-1:0];
    if (shf > MAX_V) begin
      beat_d.value = ACT_MAX;
    end else if (shf < MIN_V) begin
      beat_d.value = ACT_MIN;
    end else begin
      beat_d.sat = 1'b0;
    end
  end

  assign load      = !res_valid || res_ready;
  assign sum_ready = load;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else if (load) begin
      res_valid <= sum_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load && sum_valid) begin
      res <= beat_d;
    end
  end

  a_res_stable: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid && !res_ready |=> $stable(res))
    else $error("fixed_round_sat: res changed while stalled");

  // a clamped value always sits on a rail
  a_sat_on_rail: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> !(res.sat && res.value > ACT_MIN && res.value < ACT_MAX))
    else $error("fixed_round_sat: sat set for an in-range value");

endmodule

// ==== fixed_vector_mult.sv ====
`timescale 1ns/1ps

module fixed_vector_mult #(
  parameter int IN_SIZE = 4
) (
  input  logic                              clk,
  input  logic                              rst_n,

  // activation stream
  input  dp_num_pkg::act_t [IN_SIZE-1:0]    act,
  input  logic                              act_valid,
  output logic                              act_ready,

  // weight stream
  input  dp_num_pkg::wgt_t [IN_SIZE-1:0]    wgt,
  input  logic                              wgt_valid,
  output logic                              wgt_ready,

  // element-wise products
  output dp_num_pkg::prod_t [IN_SIZE-1:0]   prod,
  output logic                              prod_valid,
  input  logic                              prod_ready
);

  dp_num_pkg::prod_t [IN_SIZE-1:0] prod_d;
  logic                            load;
  logic                            accept;

  // register is free or being drained this cycle
  assign load = !prod_valid || prod_ready;

  // each ready waits on the other stream's valid
  // so a lone stream is never consumed
  assign act_ready = load && wgt_valid;
  assign wgt_ready = load && act_valid;

  assign accept = load && act_valid && wgt_valid;

  // signed multiply per element, full width
  always_comb begin
    for (int i = 0; i < IN_SIZE; i++) begin
      prod_d[i] = $signed(act[i]) * $signed(wgt[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_valid <= 1'b0;
    end else if (load) begin
      prod_valid <= accept;
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (accept) begin
      prod <= prod_d;
    end
  end

  // products held while the adder tree stalls
  property p_prod_stable;
    @(posedge clk) disable iff (!rst_n)
      prod_valid && !prod_ready |=> $stable(prod);
  endproperty

  a_prod_stable: assert property (p_prod_stable)
    else $error("fixed_vector_mult: prod changed while stalled");

endmodule

// ==== flist.f ====
+incdir+.
dp_num_pkg.sv
dp_stream_pkg.sv
fixed_vector_mult.sv
fixed_adder_tree.sv
fixed_dot_product.sv
fixed_round_sat.sv
fixed_linear_unit.sv
tb_fixed_linear_unit.sv

// ==== tb_dp_tasks.svh ====
// reference model of the datapath arithmetic
// exact dot product, add half an output lsb, drop 6 bits, clamp to 16 bits
function automatic dp_stream_pkg::out_beat_t expected_beat(
  input act_vec_t a,
  input wgt_vec_t w
);
  dp_stream_pkg::out_beat_t b;
  longint acc;
  longint q;
  acc = 0;
  for (int i = 0; i < in_size; i++) begin
    acc += longint'(a[i]) * longint'(w[i]);
  end
  q = (acc + 32) >>> 6;
  b.sat   = 1'b0;
  b.value = q[15:0];
  if (q > 32767) begin
    b.value = 16'sh7fff;
    b.sat   = 1'b1;
  end else if (q < -32768) begin
    b.value = 16'sh8000;
    b.sat   = 1'b1;
  end
  return b;
endfunction

// compare one transferred beat with the oldest expected one
task automatic check_beat(input dp_stream_pkg::out_beat_t got);
  exp_t e;
  if (exp_q.size() == 0) begin
    $display("a result beat arrived at %0t with no vector pair waiting for it", $time);
    errors++;
  end else begin
    e = exp_q.pop_front();
    if (got !== e.beat) begin
      $display("FAIL %0t: expected value %0d sat %0b, got value %0d sat %0b",
               $time, e.beat.value, e.beat.sat, got.value, got.sat);
      errors++;
    end
    if (check_lat && (cyc - e.stamp) != 4) begin
      $display("FAIL %0t: result took %0d cycles, expected 4", $time, cyc - e.stamp);
      errors++;
    end
  end
endtask

task automatic random_pair(output act_vec_t a, output wgt_vec_t w);
  for (int i = 0; i < in_size; i++) begin
    a[i] = dp_num_pkg::act_t'($random(seed));
    w[i] = dp_num_pkg::wgt_t'($random(seed));
  end
endtask

task automatic drive_pair(input act_vec_t a, input wgt_vec_t w);
  @(negedge clk);
  act       = a;
  wgt       = w;
  act_valid = 1'b1;
  wgt_valid = 1'b1;
endtask

// edges counts the rising edges up to and including the accepting one
task automatic wait_accept(output int edges);
  edges = 0;
  do begin
    @(posedge clk);
    edges++;
  end while (!(act_valid && act_ready));
endtask

task automatic send_pair(input act_vec_t a, input wgt_vec_t w, output int edges);
  drive_pair(a, w);
  wait_accept(edges);
endtask

task automatic idle();
  @(negedge clk);
  act_valid = 1'b0;
  wgt_valid = 1'b0;
endtask

task automatic wait_drain();
  int n;
  n = 0;
  while (exp_q.size() != 0 && n < 200) begin
    @(negedge clk);
    n++;
  end
  if (exp_q.size() != 0) begin
    $display("%0d results still missing %0d cycles after the last vector", exp_q.size(), n);
    errors++;
  end
endtask

// one pair on its own, then wait for its result
task automatic run_one(input act_vec_t a, input wgt_vec_t w);
  int edges;
  send_pair(a, w, edges);
  idle();
  wait_drain();
endtask

task automatic test_single();
  check_lat = 1'b1;
  run_one('0, '0);
  // 1.0 times 1.0 in every lane
  run_one({4{16'sh0100}}, {4{8'sh40}});
  run_one({16'sh0180, -16'sh0200, 16'sh0100, -16'sh0080},
          {8'sh40, 8'sh20, -8'sh10, -8'sh40});
  run_one({16'sh0003, 16'shfffd, 16'sh0011, 16'sh0100}, {8'sh05, 8'sh07, -8'sh03, -8'sh01});
  check_lat = 1'b0;
endtask

task automatic test_stream();
  act_vec_t a;
  wgt_vec_t w;
  int       edges;
  check_lat = 1'b1;
  for (int k = 0; k < vec_per_test; k++) begin
    random_pair(a, w);
    send_pair(a, w, edges);
    if (edges != 1) begin
      $display("FAIL %0t: vector %0d waited %0d cycles to be accepted", $time, k, edges);
      errors++;
    end
  end
  idle();
  wait_drain();
  check_lat = 1'b0;
endtask

task automatic test_backpressure();
  act_vec_t a;
  wgt_vec_t w;
  int       edges;
  res_ready = 1'b0;
  // four pairs fill multiplier, both tree levels and the output register
  for (int k = 0; k < 4; k++) begin
    random_pair(a, w);
    send_pair(a, w, edges);
  end
  random_pair(a, w);
  drive_pair(a, w);
  repeat (3) begin
    @(posedge clk);
    if (act_ready) begin
      $display("FAIL %0t: act_ready high with the pipeline full", $time);
      errors++;
    end
  end
  bp_on = 1'b1;
  wait_accept(edges);
  for (int k = 0; k < vec_per_test - 5; k++) begin
    random_pair(a, w);
    send_pair(a, w, edges);
  end
  idle();
  bp_on     = 1'b0;
  res_ready = 1'b1;
  wait_drain();
endtask

task automatic test_join();
  act_vec_t a;
  wgt_vec_t w;
  int       edges;
  int       acc0;
  int       beat0;
  acc0  = acc_count;
  beat0 = beat_count;
  random_pair(a, w);
  @(negedge clk);
  act       = a;
  act_valid = 1'b1;
  repeat (5) @(negedge clk);
  if (acc_count != acc0) begin
    $display("activations were accepted at %0t before any weights were valid", $time);
    errors++;
  end
  wgt       = w;
  wgt_valid = 1'b1;
  wait_accept(edges);
  idle();
  // now weights first
  random_pair(a, w);
  @(negedge clk);
  wgt       = w;
  wgt_valid = 1'b1;
  // act_valid is low, so a high wgt_ready would consume the weights alone
  repeat (5) begin
    @(posedge clk);
    if (wgt_ready) begin
      $display("weights were accepted at %0t before any activations were valid", $time);
      errors++;
    end
  end
  @(negedge clk);
  if (acc_count != acc0 + 1) begin
    $display("the first joined pair was accepted %0d times instead of once", acc_count - acc0);
    errors++;
  end
  act       = a;
  act_valid = 1'b1;
  wait_accept(edges);
  idle();
  wait_drain();
  if (beat_count != beat0 + 2) begin
    $display("two joined pairs gave %0d results instead of 2", beat_count - beat0);
    errors++;
  end
endtask

task automatic test_saturation();
  // both rails
  run_one({4{16'sh7fff}}, {4{8'sh7f}});
  run_one({4{16'sh8000}}, {4{8'sh7f}});
  run_one({4{16'sh8000}}, {4{8'sh80}});
  // sums of 32, -32 and 31 sit on or near the rounding boundary
  run_one({16'sh0000, 16'sh0000, 16'sh0000, 16'sh0001}, {8'sh00, 8'sh00, 8'sh00, 8'sh20});
  run_one({16'sh0000, 16'sh0000, 16'sh0000, 16'shffff}, {8'sh00, 8'sh00, 8'sh00, 8'sh20});
  run_one({16'sh0000, 16'sh0000, 16'sh0000, 16'sh0001}, {8'sh00, 8'sh00, 8'sh00, 8'sh1f});
  run_one({16'sh0000, 16'sh0000, 16'sh0001, 16'sh0001}, {8'sh00, 8'sh00, 8'sh20, 8'sh40});
endtask

task automatic test_reset();
  act_vec_t a;
  wgt_vec_t w;
  int       edges;
  for (int k = 0; k < 6; k++) begin
    random_pair(a, w);
    send_pair(a, w, edges);
  end
  // pull reset with vectors still in flight
  @(negedge clk);
  rst_n     = 1'b0;
  act_valid = 1'b0;
  wgt_valid = 1'b0;
  exp_q.delete();
  repeat (3) @(negedge clk);
  if (res_valid) begin
    $display("res_valid stayed high at %0t while reset was asserted", $time);
    errors++;
  end
  rst_n = 1'b1;
  @(negedge clk);
  if (res_valid) begin
    $display("res_valid went high at %0t after reset with nothing sent", $time);
    errors++;
  end
  random_pair(a, w);
  run_one(a, w);
endtask

// ==== tb_fixed_linear_unit.sv ====
`timescale 1ns/1ps

module tb_fixed_linear_unit;

  localparam int in_size      = 4;
  localparam int num_tests    = 6;
  localparam int vec_per_test = 64;
  localparam int rst_cycles   = 16;
  localparam int wd_cycles    = num_tests * vec_per_test * 20 + rst_cycles;

  typedef dp_num_pkg::act_t [in_size-1:0] act_vec_t;
  typedef dp_num_pkg::wgt_t [in_size-1:0] wgt_vec_t;

  // expected beat and the cycle its pair was accepted in
  typedef struct packed {
    dp_stream_pkg::out_beat_t beat;
    int                       stamp;
  } exp_t;

  logic                     clk;
  logic                     rst_n;
  act_vec_t                 act;
  logic                     act_valid;
  logic                     act_ready;
  wgt_vec_t                 wgt;
  logic                     wgt_valid;
  logic                     wgt_ready;
  dp_stream_pkg::out_beat_t res;
  logic                     res_valid;
  logic                     res_ready;

  integer seed;
  integer bp_seed;
  int     errors;
  int     cyc;
  int     acc_count;
  int     beat_count;
  bit     check_lat;
  bit     bp_on;
  exp_t   exp_q[$];

  fixed_linear_unit #(
    .IN_SIZE(in_size)
  ) dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .act      (act),
    .act_valid(act_valid),
    .act_ready(act_ready),
    .wgt      (wgt),
    .wgt_valid(wgt_valid),
    .wgt_ready(wgt_ready),
    .res      (res),
    .res_valid(res_valid),
    .res_ready(res_ready)
  );

  `include "tb_dp_tasks.svh"

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // expected result is computed when the pair is accepted
  always @(posedge clk) begin : accept_mon
    exp_t e;
    if (rst_n && act_valid && act_ready) begin
      e.beat  = expected_beat(act, wgt);
      e.stamp = cyc;
      exp_q.push_back(e);
      acc_count++;
    end
  end

  // output sink
  always @(posedge clk) begin
    if (rst_n && res_valid && res_ready) begin
      beat_count++;
      check_beat(res);
    end
  end

  // random stalls on the result stream
  always @(negedge clk) begin
    if (bp_on) begin
      res_ready = 1'($random(bp_seed));
    end
  end

  initial begin
    seed       = 32'h8f3df895;
    bp_seed    = 32'h8f3df895;
    clk        = 1'b0;
    rst_n      = 1'b0;
    act        = '0;
    act_valid  = 1'b0;
    wgt        = '0;
    wgt_valid  = 1'b0;
    res_ready  = 1'b1;
    errors     = 0;
    cyc        = 0;
    acc_count  = 0;
    beat_count = 0;
    check_lat  = 1'b0;
    bp_on      = 1'b0;
    repeat (rst_cycles) @(negedge clk);
    rst_n = 1'b1;
    test_single();
    test_stream();
    test_backpressure();
    test_join();
    test_saturation();
    test_reset();
    if (exp_q.size() != 0) begin
      $display("%0d expected results were never produced", exp_q.size());
      errors++;
    end
    $display("errors: %0d, beats checked: %0d", errors, beat_count);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("timeout: tests still running after %0d cycles", wd_cycles);
    $display("Done: errors found");
    $finish;
  end

endmodule
